//--- Makefile
SIM      := verilator
TOP      := tbPixelPeriphery
FILELIST := project.f
FLAGS    := --binary --timing --assert --top-module $(TOP)
OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- bcidTimer.sv
`timescale 1ns/1ps

module bcidTimer (
    input  logic                          ClkBx,
    input  logic                          resetBcid,
    output logic [pixelPkg::BcidBits-1:0] bcidGray
);
    import pixelPkg::*;

    logic                resetBcidQ; // External reset, retimed once
    logic [BcidBits-1:0] bcidBin;

    always_ff @(posedge ClkBx) begin
        resetBcidQ <= resetBcid;
    end

    // Free-running bunch counter, wraps naturally
    always_ff @(posedge ClkBx) begin
        if (resetBcidQ) begin
            bcidBin <= '0;
        end else begin
            bcidBin <= bcidBin + 1'b1;
        end
    end

    // One bit changes per count, safe to sample anywhere in the matrix
    assign bcidGray = bcidBin ^ (bcidBin >> 1);

endmodule

//--- flavorReadout.sv
`timescale 1ns/1ps

module flavorReadout #(
    parameter int  NumCols = pixelPkg::NumColsPmos,
    parameter type WordT   = pixelPkg::pmosWordT
) (
    input  logic                          ClkBx,
    input  logic                          reset_ff,
    input  logic [NumCols-1:0]            colHits,
    input  logic [NumCols-1:0]            colMask,
    input  logic                          enable,
    input  logic                          enTestPattern,
    input  logic                          freeze,
    input  logic [pixelPkg::BcidBits-1:0] bcidGray,
    input  logic                          readAck,
    output logic                          tokReq,
    output WordT                          word,
    output logic                          hitFlag
);
    import pixelPkg::*;

    // Column field is whatever the word leaves above the timestamp
    localparam int ColBits = $bits(WordT) - BcidBits;

    logic [NumCols-1:0] maskedHits;
    logic [NumCols-1:0] doneMask; // Columns already sent this freeze
    logic [NumCols-1:0] pendHits;
    logic               tpDone;   // Test word already sent this freeze

    logic               hitAny;
    logic [ColBits-1:0] hitCol;
    logic               pendAny;
    logic [ColBits-1:0] pendCol;
    logic               capture;

    assign maskedHits = colHits & colMask;
    assign pendHits   = maskedHits & ~doneMask;

    // Lowest pending column wins
    always_comb begin
        hitAny = 1'b0;
        hitCol = '0;
        for (int i = NumCols - 1; i >= 0; i--) begin
            if (pendHits[i]) begin
                hitAny = 1'b1;
                hitCol = ColBits'(i);
            end
        end
    end

    // Test pattern replaces the matrix with one fixed word
    always_comb begin
        if (enTestPattern) begin
            pendAny = !tpDone;
            pendCol = '1;
        end else begin
            pendAny = hitAny;
            pendCol = hitCol;
        end
    end

    // Previous token fully retired once ack is back low
    assign capture = freeze && enable && !tokReq && !readAck && pendAny;

    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            doneMask <= '0;
            tpDone   <= 1'b0;
        end else if (!freeze) begin
            doneMask <= '0; // Next freeze starts clean
            tpDone   <= 1'b0;
        end else if (capture) begin
            if (enTestPattern) begin
                tpDone <= 1'b1;
            end else begin
                doneMask[pendCol] <= 1'b1;
            end
        end
    end

    // Token handshake
    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            tokReq <= 1'b0;
        end else if (capture) begin
            tokReq <= 1'b1;
        end else if (tokReq && readAck) begin
            tokReq <= 1'b0;
        end
    end

    // Word held stable for the whole token
    always_ff @(posedge ClkBx) begin
        if (capture) begin
            word <= WordT'({pendCol, bcidGray});
        end
    end

    // Fast monitor, independent of readout enable
    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            hitFlag <= 1'b0;
        end else begin
            hitFlag <= |maskedHits;
        end
    end

endmodule

//--- periphConfig.sv
`timescale 1ns/1ps

module periphConfig (
    input  logic           ClkBx,
    input  logic           reset_ff,
    input  logic           confSi,
    input  logic           confShift,
    input  logic           loadReq,
    output logic           confSo,
    output logic           loadAck,
    output pixelPkg::confT conf
);
    import pixelPkg::*;

    // Shift register, loaded bit by bit from confSi
    logic [ConfBits-1:0] shadow;

    // Load handshake edges
    logic loadStart;
    logic loadDone;

    assign loadStart = loadReq && !loadAck;
    assign loadDone  = !loadReq && loadAck;

    // Serial chain, new bit enters at the LSB
    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            shadow <= ConfDefault;
        end else if (confShift) begin
            shadow <= {shadow[ConfBits-2:0], confSi};
        end
    end

    // MSB leaves first so a read-back sees the word in chain order
    assign confSo = shadow[ConfBits-1];

    // Active copy, changes only on a new load request
    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            conf <= ConfDefault;
        end else if (loadStart) begin
            conf <= confT'(shadow);
        end
    end

    // Four-phase ack
    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            loadAck <= 1'b0;
        end else if (loadStart) begin
            loadAck <= 1'b1; // Same edge as the copy
        end else if (loadDone) begin
            loadAck <= 1'b0;
        end
    end

endmodule

//--- pixelPeriphery.sv
`timescale 1ns/1ps

module pixelPeriphery (
    input  logic                             ClkBx,
    input  logic                             reset_ff,
    input  logic                             resetBcid,
    input  logic                             confSi,
    input  logic                             confShift,
    input  logic                             loadReq,
    input  logic [pixelPkg::NumColsPmos-1:0] hitsPmos,
    input  logic [pixelPkg::NumColsHv-1:0]   hitsHv,
    input  logic                             freezePmos,
    input  logic                             freezeHv,
    input  logic                             outAck,
    output logic                             confSo,
    output logic                             loadAck,
    output logic                             outReq,
    output pixelPkg::outWordT                outWord,
    output logic [1:0]                       hitOr
);
    import pixelPkg::*;

    confT                conf;
    logic [BcidBits-1:0] bcidGray;

    // Flavor streams into the merger
    logic     pmosReq, pmosAck, pmosHit;
    pmosWordT pmosWord;
    logic     hvReq, hvAck, hvHit;
    hvWordT   hvWord;

    periphConfig i_periphConfig (
        .ClkBx     (ClkBx),
        .reset_ff  (reset_ff),
        .confSi    (confSi),
        .confShift (confShift),
        .loadReq   (loadReq),
        .confSo    (confSo),
        .loadAck   (loadAck),
        .conf      (conf)
    );

    bcidTimer i_bcidTimer (
        .ClkBx     (ClkBx),
        .resetBcid (resetBcid),
        .bcidGray  (bcidGray)
    );

    flavorReadout #(
        .NumCols (NumColsPmos),
        .WordT   (pmosWordT)
    ) i_readoutPmos (
        .ClkBx         (ClkBx),
        .reset_ff      (reset_ff),
        .colHits       (hitsPmos),
        .colMask       (conf.maskPmos),
        .enable        (conf.enPmos),
        .enTestPattern (conf.enTestPattern[0]),
        .freeze        (freezePmos),
        .bcidGray      (bcidGray),
        .readAck       (pmosAck),
        .tokReq        (pmosReq),
        .word          (pmosWord),
        .hitFlag       (pmosHit)
    );

    flavorReadout #(
        .NumCols (NumColsHv),
        .WordT   (hvWordT)
    ) i_readoutHv (
        .ClkBx         (ClkBx),
        .reset_ff      (reset_ff),
        .colHits       (hitsHv),
        .colMask       (conf.maskHv),
        .enable        (conf.enHv),
        .enTestPattern (conf.enTestPattern[1]),
        .freeze        (freezeHv),
        .bcidGray      (bcidGray),
        .readAck       (hvAck),
        .tokReq        (hvReq),
        .word          (hvWord),
        .hitFlag       (hvHit)
    );

    readoutMerger i_readoutMerger (
        .ClkBx    (ClkBx),
        .reset_ff (reset_ff),
        .pmosReq  (pmosReq),
        .pmosWord (pmosWord),
        .hvReq    (hvReq),
        .hvWord   (hvWord),
        .pmosHit  (pmosHit),
        .hvHit    (hvHit),
        .enHitOr  (conf.enHitOr),
        .outAck   (outAck),
        .pmosAck  (pmosAck),
        .hvAck    (hvAck),
        .outReq   (outReq),
        .outWord  (outWord),
        .hitOr    (hitOr)
    );

endmodule

//--- pixelPkg.sv
package pixelPkg;

    // Timestamp width, shared by the BCID counter and every readout word
    localparam int BcidBits = 6;

    // Columns per flavor
    localparam int NumColsPmos = 16;
    localparam int NumColsHv   = 8;

    // PMOS word, column index above the timestamp
    typedef struct packed {
        logic [3:0]          col;
        logic [BcidBits-1:0] bcid;
    } pmosWordT;

    // HV word, 8 columns need only 3 index bits
    typedef struct packed {
        logic [2:0]          col;
        logic [BcidBits-1:0] bcid;
    } hvWordT;

    // Merged output word
    typedef struct packed {
        logic                flavor; // 0 PMOS, 1 HV
        logic [3:0]          col;    // HV index zero-extended
        logic [BcidBits-1:0] bcid;
    } outWordT;

    // Global configuration, MSB first in the serial chain
    // Bit 0 of each two-bit field is PMOS
    typedef struct packed {
        logic                   enPmos;
        logic                   enHv;
        logic [1:0]             enTestPattern;
        logic [1:0]             enHitOr;
        logic [NumColsPmos-1:0] maskPmos; // 1 = column enabled
        logic [NumColsHv-1:0]   maskHv;
    } confT;

    localparam int ConfBits = $bits(confT);

    // Power-on state: readout off, test pattern armed, hit-OR quiet
    localparam confT ConfDefault = '{
        enPmos:        1'b0,
        enHv:          1'b0,
        enTestPattern: 2'b11,
        enHitOr:       2'b00,
        maskPmos:      '1,
        maskHv:        '1
    };

endpackage

//--- project.f
pixelPkg.sv
periphConfig.sv
bcidTimer.sv
flavorReadout.sv
readoutMerger.sv
pixelPeriphery.sv
tbPixelPeriphery.sv

//--- readoutMerger.sv
`timescale 1ns/1ps

module readoutMerger (
    input  logic              ClkBx,
    input  logic              reset_ff,
    input  logic              pmosReq,
    input  pixelPkg::pmosWordT pmosWord,
    input  logic              hvReq,
    input  pixelPkg::hvWordT  hvWord,
    input  logic              pmosHit,
    input  logic              hvHit,
    input  logic [1:0]        enHitOr,
    input  logic              outAck,
    output logic              pmosAck,
    output logic              hvAck,
    output logic              outReq,
    output pixelPkg::outWordT outWord,
    output logic [1:0]        hitOr
);
    import pixelPkg::*;

    logic lastHv;     // Flavor served most recently
    logic pmosValid;  // Token up and not yet taken
    logic hvValid;
    logic canAccept;  // Buffer empty and output handshake idle
    logic grantPmos;
    logic grantHv;

    assign pmosValid = pmosReq && !pmosAck;
    assign hvValid   = hvReq && !hvAck;
    assign canAccept = !outReq && !outAck;

    // Round robin, ties go to the flavor not served last
    assign grantPmos = canAccept && pmosValid && (!hvValid || lastHv);
    assign grantHv   = canAccept && hvValid && (!pmosValid || !lastHv);

    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            lastHv <= 1'b1; // PMOS first after reset
        end else if (grantPmos) begin
            lastHv <= 1'b0;
        end else if (grantHv) begin
            lastHv <= 1'b1;
        end
    end

    // Upstream acks, dropped once the token is seen low
    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            pmosAck <= 1'b0;
            hvAck   <= 1'b0;
        end else begin
            if (grantPmos) begin
                pmosAck <= 1'b1;
            end else if (!pmosReq) begin
                pmosAck <= 1'b0;
            end
            if (grantHv) begin
                hvAck <= 1'b1;
            end else if (!hvReq) begin
                hvAck <= 1'b0;
            end
        end
    end

    // Output buffer, outReq doubles as the full flag
    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            outReq <= 1'b0;
        end else if (grantPmos || grantHv) begin
            outReq <= 1'b1;
        end else if (outReq && outAck) begin
            outReq <= 1'b0;
        end
    end

    always_ff @(posedge ClkBx) begin
        if (grantPmos) begin
            outWord <= outWordT'{flavor: 1'b0, col: pmosWord.col, bcid: pmosWord.bcid};
        end else if (grantHv) begin
            outWord <= outWordT'{flavor: 1'b1, col: {1'b0, hvWord.col}, bcid: hvWord.bcid};
        end
    end

    // Hit-OR, gated by config
    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            hitOr <= '0;
        end else begin
            hitOr <= {hvHit, pmosHit} & enHitOr;
        end
    end

endmodule

//--- tbPixelPeriphery.sv
`timescale 1ns/1ps

module tbPixelPeriphery;
    import pixelPkg::*;

    localparam int DriveDelay = 1;   // ns after the rising edge
    localparam int MaxWait    = 200;
    localparam int TpDelay    = 23;  // Cycles from BCID release to freeze

    typedef struct {
        confT        conf;
        logic [15:0] pmosHits;
        logic [7:0]  hvHits;
        logic [1:0]  freezeSel; // Bit 0 PMOS
        int          expCount;  // -1 when the hits are random
    } stimT;

    logic                   ClkBx = 1'b0;
    logic                   reset_ff, resetBcid, confSi, confShift, loadReq;
    logic                   freezePmos, freezeHv, outAck;
    logic [NumColsPmos-1:0] hitsPmos;
    logic [NumColsHv-1:0]   hitsHv;
    logic                   confSo, loadAck, outReq;
    logic [1:0]             hitOr;
    outWordT                outWord;

    stimT    stim [6];
    outWordT expQ [$];
    logic    lastFlavor = 1'b1; // HV counts as last served after reset
    confT    prevConf;
    confT    readBack;
    logic [1:0] expHitOr;

    always #2 ClkBx = ~ClkBx;

    pixelPeriphery i_pixelPeriphery (.*);

    task automatic nextCycle();
        @(posedge ClkBx);
        #DriveDelay;
    endtask

    task automatic stopOnError(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else
            stopOnError($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
    endtask

    // Each Gray bit flags a difference between neighboring binary bits
    function automatic logic [5:0] toGray(input logic [5:0] bin);
        logic [5:0] gray;
        gray[5] = bin[5];
        for (int i = 4; i >= 0; i--) begin
            gray[i] = bin[i + 1] ^ bin[i];
        end
        return gray;
    endfunction

    // New word goes in while the old one comes out of confSo MSB first
    task automatic shiftConf(input confT din, output confT dout);
        for (int i = ConfBits - 1; i >= 0; i--) begin
            dout[i]   = confSo;
            confSi    = din[i];
            confShift = 1'b1;
            nextCycle();
        end
        confShift = 1'b0;
    endtask

    // One phase of the load handshake where ack must follow in exactly one cycle
    task automatic handshakeLoad(input logic level);
        int cycles;
        cycles  = 0;
        loadReq = level;
        do begin
            nextCycle();
            cycles++;
        end while (loadAck !== level && cycles < 10);
        checkValue("loadAck latency", 32'(cycles), 32'd1);
    endtask

    // Masked columns in ascending order with flavors merged round robin
    task automatic buildExpected(input stimT s);
        outWordT qp [$];
        outWordT qh [$];
        if (s.freezeSel[0] && s.conf.enPmos) begin
            if (s.conf.enTestPattern[0]) begin
                qp.push_back({1'b0, 4'hF, 6'd0});
            end else begin
                for (int i = 0; i < NumColsPmos; i++) begin
                    if (s.pmosHits[i] && s.conf.maskPmos[i]) qp.push_back({1'b0, 4'(i), 6'd0});
                end
            end
        end
        if (s.freezeSel[1] && s.conf.enHv) begin
            if (s.conf.enTestPattern[1]) begin
                qh.push_back({1'b1, 4'h7, 6'd0}); // 3-bit all ones zero-extended
            end else begin
                for (int i = 0; i < NumColsHv; i++) begin
                    if (s.hvHits[i] && s.conf.maskHv[i]) qh.push_back({1'b1, 4'(i), 6'd0});
                end
            end
        end
        while (qp.size() > 0 || qh.size() > 0) begin
            if (qh.size() == 0 || (qp.size() > 0 && lastFlavor)) begin
                expQ.push_back(qp.pop_front());
                lastFlavor = 1'b0;
            end else begin
                expQ.push_back(qh.pop_front());
                lastFlavor = 1'b1;
            end
        end
    endtask

    // Output handshake with a random ack delay
    task automatic collectWords();
        int waitCnt;
        int delay;
        while (expQ.size() > 0) begin
            waitCnt = 0;
            while (!outReq && waitCnt < MaxWait) begin
                nextCycle();
                waitCnt++;
            end
            assert (outReq) else stopOnError("timeout waiting for outReq");
            checkValue("outWord", 32'(outWord), 32'(expQ.pop_front()));
            delay = $urandom % 4;
            repeat (delay) nextCycle();
            outAck  = 1'b1;
            waitCnt = 0;
            while (outReq && waitCnt < MaxWait) begin
                nextCycle();
                waitCnt++;
            end
            assert (!outReq) else stopOnError("outReq stayed high after outAck");
            outAck = 1'b0;
        end
    endtask

    task automatic checkQuiet();
        repeat (20) begin
            nextCycle();
            assert (!outReq) else stopOnError($sformatf("unexpected extra word 0x%h", outWord));
        end
    endtask

    initial begin
        reset_ff   = 1'b1;
        resetBcid  = 1'b1; // Held so every readout word carries BCID 0
        confSi     = 1'b0;
        confShift  = 1'b0;
        loadReq    = 1'b0;
        hitsPmos   = '0;
        hitsHv     = '0;
        freezePmos = 1'b0;
        freezeHv   = 1'b0;
        outAck     = 1'b0;
        void'($urandom(42832));
        // conf {enPmos, enHv, testPattern, hitOr, maskPmos, maskHv}, hits, freeze, count
        stim[0] = '{confT'({1'b1, 1'b0, 2'b00, 2'b01, 16'hF0F0, 8'hFF}),
                    16'h0FF1, 8'h0F, 2'b11, 4};
        stim[1] = '{confT'({1'b0, 1'b1, 2'b00, 2'b10, 16'hFFFF, 8'hA5}),
                    16'h8001, 8'h3C, 2'b10, 2};
        stim[2] = '{confT'({1'b0, 1'b0, 2'b00, 2'b11, 16'hFFFF, 8'hFF}),
                    16'h1234, 8'h81, 2'b11, 0};
        stim[3] = '{confT'({1'b1, 1'b1, 2'b00, 2'b11, 16'hFFFF, 8'hFF}),
                    16'($urandom()), 8'($urandom()), 2'b11, -1};
        stim[4] = '{confT'({1'b1, 1'b1, 2'b10, 2'b00, 16'hFFFF, 8'h00}),
                    16'h0003, 8'hFF, 2'b11, 3};
        stim[5] = '{confT'({1'b1, 1'b1, 2'b00, 2'b11, 16'h00FF, 8'h00}),
                    16'h0F0F, 8'hFF, 2'b11, 4};
        repeat (4) nextCycle();
        reset_ff = 1'b0;
        checkValue("outReq", 32'(outReq), 32'd0);
        checkValue("loadAck", 32'(loadAck), 32'd0);
        checkValue("hitOr", 32'(hitOr), 32'd0);
        prevConf = confT'({1'b0, 1'b0, 2'b11, 2'b00, 16'hFFFF, 8'hFF}); // Power-on layout
        foreach (stim[n]) begin
            shiftConf(stim[n].conf, readBack);
            checkValue("confSo read-back", 32'(readBack), 32'(prevConf));
            prevConf = stim[n].conf;
            handshakeLoad(1'b1);
            handshakeLoad(1'b0);
            hitsPmos = stim[n].pmosHits;
            hitsHv   = stim[n].hvHits;
            expHitOr = {|(hitsHv & prevConf.maskHv), |(hitsPmos & prevConf.maskPmos)};
            nextCycle();
            checkValue("hitOr", 32'(hitOr), 32'd0); // Hits still one stage away
            nextCycle();
            checkValue("hitOr", 32'(hitOr), 32'(expHitOr & prevConf.enHitOr));
            buildExpected(stim[n]);
            if (stim[n].expCount >= 0) begin
                checkValue("word count", 32'(expQ.size()), 32'(stim[n].expCount));
            end
            freezePmos = stim[n].freezeSel[0];
            freezeHv   = stim[n].freezeSel[1];
            collectWords();
            checkQuiet(); // Catches duplicates and disabled flavors
            freezePmos = 1'b0;
            freezeHv   = 1'b0;
            hitsPmos   = '0;
            hitsHv     = '0;
            nextCycle();
        end
        shiftConf(confT'({1'b1, 1'b0, 2'b01, 2'b00, 16'hFFFF, 8'hFF}), readBack);
        checkValue("confSo read-back", 32'(readBack), 32'(prevConf));
        handshakeLoad(1'b1);
        handshakeLoad(1'b0);
        resetBcid = 1'b0;
        repeat (TpDelay) nextCycle();
        freezePmos = 1'b1; // One-cycle freeze pulse
        nextCycle();
        freezePmos = 1'b0;
        expQ.push_back({1'b0, 4'hF, toGray(6'(TpDelay - 1))}); // Count k-1 at capture
        collectWords();
        checkQuiet();
        $display("All tests passed!");
        $finish;
    end

endmodule
